// ==== div_patterns.txt ====
# name signed word dividend divisor quotient remainder
# all values hex, word ops read only the low 32 bits of the operands
udw_all_ones_by3 0 0 ffffffffffffffff 0000000000000003 5555555555555555 0000000000000000
udw_min_by_ones 0 0 8000000000000000 ffffffffffffffff 0000000000000000 8000000000000000
udw_top_bit 0 0 fedcba9876543210 8000000000000000 0000000000000001 7edcba9876543210
udw_odd_by2 0 0 8000000000000001 0000000000000002 4000000000000000 0000000000000001
udw_by_word_max 0 0 ffffffffffffffff 00000000ffffffff 0000000100000001 0000000000000000
udw_zero_dividend 0 0 0000000000000000 0000000000000005 0000000000000000 0000000000000000
udw_exact 0 0 0000000000000064 000000000000000a 000000000000000a 0000000000000000
sdw_pos_pos 1 0 0000000000000007 0000000000000002 0000000000000003 0000000000000001
sdw_neg_pos 1 0 fffffffffffffff9 0000000000000002 fffffffffffffffd ffffffffffffffff
sdw_pos_neg 1 0 0000000000000007 fffffffffffffffe fffffffffffffffd 0000000000000001
sdw_neg_neg 1 0 fffffffffffffff9 fffffffffffffffe 0000000000000003 ffffffffffffffff
sdw_min_by2 1 0 8000000000000000 0000000000000002 c000000000000000 0000000000000000
sdw_neg100_by7 1 0 ffffffffffffff9c 0000000000000007 fffffffffffffff2 fffffffffffffffe
sdw_min_by3 1 0 8000000000000000 0000000000000003 d555555555555556 fffffffffffffffe
sdw_minus1_by2 1 0 ffffffffffffffff 0000000000000002 0000000000000000 ffffffffffffffff
sdw_max_by_min 1 0 7fffffffffffffff 8000000000000000 0000000000000000 7fffffffffffffff
sdw_min_by1 1 0 8000000000000000 0000000000000001 8000000000000000 0000000000000000
uw_upper_ignored 0 1 deadbeef00000064 1234567800000007 000000000000000e 0000000000000002
uw_quot_bit31 0 1 aaaaaaaafffffffe 5555555500000001 fffffffffffffffe 0000000000000000
uw_half_by3 0 1 1111111180000000 0000000000000003 000000002aaaaaaa 0000000000000002
uw_rem_bit31 0 1 0000000090000000 00000000a0000000 0000000000000000 ffffffff90000000
uw_max_by16 0 1 00000000ffffffff 0000000000000010 000000000fffffff 000000000000000f
uw_divisor_upper 0 1 00000000000000ff ffffffff00000010 000000000000000f 000000000000000f
uw_min_by_ones 0 1 0000000080000000 00000000ffffffff 0000000000000000 ffffffff80000000
sw_neg_pos 1 1 00000000fffffff9 0000000000000002 fffffffffffffffd ffffffffffffffff
sw_pos_neg 1 1 7fffffff00000064 fffffffffffffff9 fffffffffffffff2 0000000000000002
sw_neg_neg 1 1 00000000fffffff9 00000000fffffffe 0000000000000003 ffffffffffffffff
sw_big_neg_by16 1 1 1234567880000001 0000000000000010 fffffffff8000001 fffffffffffffff1
sw_min_by1 1 1 0000000080000000 0000000000000001 ffffffff80000000 0000000000000000
dz_udw 0 0 123456789abcdef0 0000000000000000 ffffffffffffffff 123456789abcdef0
dz_sdw 1 0 8000000000000005 0000000000000000 ffffffffffffffff 8000000000000005
dz_uw 0 1 ffffffff12345678 ffffffff00000000 ffffffffffffffff 0000000012345678
dz_uw_neg 0 1 0000000087654321 0000000000000000 ffffffffffffffff ffffffff87654321
dz_sw 1 1 0000000087654321 0000000100000000 ffffffffffffffff ffffffff87654321
ovf_dw 1 0 8000000000000000 ffffffffffffffff 8000000000000000 0000000000000000
ovf_w 1 1 0000000080000000 00000000ffffffff ffffffff80000000 0000000000000000
ovf_w_upper 1 1 5555555580000000 12345678ffffffff ffffffff80000000 0000000000000000

// ==== all.f ====
div_isa_pkg.sv
div_core_pkg.sv
div_operand_prep.sv
div_iter_core.sv
div_result_fix.sv
alu_div_top.sv
tb_alu_div.sv

// ==== Makefile ====
SRCS := $(shell cat all.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_alu_div: all.f $(SRCS)
	verilator --binary --top-module tb_alu_div -Wno-fatal -f all.f

# pass only when the pass line shows up in the output
run: obj_dir/Vtb_alu_div
	@out="$$(./obj_dir/Vtb_alu_div)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^All tests passed$$"

clean:
	rm -rf obj_dir

// ==== tb_alu_div.sv ====
`timescale 1ns/10ps

module tb_alu_div
  import div_isa_pkg::*;
  import div_core_pkg::*;
();

  localparam int NAME_W = 8 * 24;
  localparam int TIMEOUT = 100;
  localparam int N_RANDOM = 200;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic            clk;
  logic            rst_i;
  logic            signed_valid_i;
  logic            div32_valid_i;
  logic [XLEN-1:0] sr1_data_i;
  logic [XLEN-1:0] sr2_data_i;
  logic            div_valid_i;
  logic            div_ready_o;
  logic [XLEN-1:0] div_out_o;
  logic [XLEN-1:0] rem_out_o;

  // random source state
  logic [31:0]     lfsr;

  alu_div_top #(
    .STEP_BITS (2)
  ) dut0 (
    .clk            (clk),
    .rst_i          (rst_i),
    .signed_valid_i (signed_valid_i),
    .div32_valid_i  (div32_valid_i),
    .sr1_data_i     (sr1_data_i),
    .sr2_data_i     (sr2_data_i),
    .div_valid_i    (div_valid_i),
    .div_ready_o    (div_ready_o),
    .div_out_o      (div_out_o),
    .rem_out_o      (rem_out_o)
  );

  // 100 ns period
  always #50 clk = ~clk;

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    abort_run();
  endtask

  task automatic check_quot(input logic [NAME_W-1:0] name, input xlen_word_u exp,
                            input xlen_word_u act);
    if (act.dw !== exp.dw) begin
      $display("ERROR %0s quotient expected %h actual %h", name, exp.dw, act.dw);
      abort_run();
    end
  endtask

  task automatic check_rem(input logic [NAME_W-1:0] name, input xlen_word_u exp,
                           input xlen_word_u act);
    if (act.dw !== exp.dw) begin
      $display("ERROR %0s remainder expected %h actual %h", name, exp.dw, act.dw);
      abort_run();
    end
  endtask

  // one galois shift with the output bit in s[0]
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // ISA reference with truncating division and a remainder signed like the dividend
  function automatic div_res_t ref_model(input logic sgn, input logic wrd,
                                         input logic [63:0] a, input logic [63:0] b);
    div_res_t           res;
    logic [31:0]        q32;
    logic [31:0]        r32;
    logic signed [31:0] sa32;
    logic signed [31:0] sb32;
    logic [63:0]        q64;
    logic [63:0]        r64;
    logic signed [63:0] sa64;
    logic signed [63:0] sb64;
    sa32 = a[31:0];
    sb32 = b[31:0];
    sa64 = a;
    sb64 = b;
    if (wrd) begin
      if (b[31:0] == 32'h0) begin
        q32 = '1;
        r32 = a[31:0];
      end else if (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff) begin
        q32 = a[31:0];
        r32 = '0;
      end else if (sgn) begin
        q32 = sa32 / sb32;
        r32 = sa32 % sb32;
      end else begin
        q32 = a[31:0] / b[31:0];
        r32 = a[31:0] % b[31:0];
      end
      // word results always sign extended from bit 31
      q64 = {{32{q32[31]}}, q32};
      r64 = {{32{r32[31]}}, r32};
    end else begin
      if (b == 64'h0) begin
        q64 = '1;
        r64 = a;
      end else if (sgn && a == 64'h8000_0000_0000_0000 && b == '1) begin
        q64 = a;
        r64 = '0;
      end else if (sgn) begin
        q64 = sa64 / sb64;
        r64 = sa64 % sb64;
      end else begin
        q64 = a / b;
        r64 = a % b;
      end
    end
    res.quot.dw = q64;
    res.rem.dw  = r64;
    return res;
  endfunction

  // one-cycle start pulse driven between rising edges
  task automatic start_division(input logic sgn, input logic wrd,
                                input logic [63:0] a, input logic [63:0] b);
    @(negedge clk);
    signed_valid_i = sgn;
    div32_valid_i  = wrd;
    sr1_data_i     = a;
    sr2_data_i     = b;
    div_valid_i    = 1'b1;
    @(negedge clk);
    div_valid_i    = 1'b0;
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (div_ready_o !== 1'b1) begin
      if (cycles >= TIMEOUT) begin
        report_failure("timeout waiting for div_ready_o");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic run_case(input logic [NAME_W-1:0] name, input logic sgn, input logic wrd,
                          input logic [63:0] a, input logic [63:0] b,
                          input xlen_word_u exp_q, input xlen_word_u exp_r);
    xlen_word_u act_q;
    xlen_word_u act_r;
    start_division(sgn, wrd, a, b);
    wait_ready();
    act_q.dw = div_out_o;
    act_r.dw = rem_out_o;
    check_quot(name, exp_q, act_q);
    check_rem(name, exp_r, act_r);
  endtask

  task automatic replay_patterns();
    int                fd;
    int                n;
    int                count;
    string             line;
    logic [NAME_W-1:0] name;
    logic [63:0]       sgn;
    logic [63:0]       wrd;
    logic [63:0]       a;
    logic [63:0]       b;
    xlen_word_u        q;
    xlen_word_u        r;
    fd = $fopen("div_patterns.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open div_patterns.txt");
    end
    count = 0;
    while ($fgets(line, fd) != 0) begin
      // skip comments and blank lines
      if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h", name, sgn, wrd, a, b, q.dw, r.dw);
        if (n != 7) begin
          report_failure("malformed line in div_patterns.txt");
        end
        run_case(name, sgn[0], wrd[0], a, b, q, r);
        count++;
      end
    end
    $fclose(fd);
    if (count == 0) begin
      report_failure("no patterns found in div_patterns.txt");
    end
    $display("%0d directed patterns checked", count);
  endtask

  // a start pulse during RUN must be dropped
  task automatic check_extra_start();
    logic [NAME_W-1:0] name;
    div_res_t          exp;
    div_res_t          exp_next;
    xlen_word_u        held_q;
    xlen_word_u        held_r;
    int                cycles;
    name = "extra_start";
    exp  = ref_model(1'b0, 1'b0, 64'hfedc_ba98_7654_3210, 64'h0000_0000_0000_0123);
    start_division(1'b0, 1'b0, 64'hfedc_ba98_7654_3210, 64'h0000_0000_0000_0123);
    repeat (3) @(negedge clk);
    // would finish fast as a word divide by zero if it were taken
    signed_valid_i = 1'b1;
    div32_valid_i  = 1'b1;
    sr1_data_i     = 64'h0000_0000_0000_0005;
    sr2_data_i     = '0;
    div_valid_i    = 1'b1;
    @(negedge clk);
    div_valid_i    = 1'b0;
    wait_ready();
    held_q.dw = div_out_o;
    held_r.dw = rem_out_o;
    check_quot(name, exp.quot, held_q);
    check_rem(name, exp.rem, held_r);
    // no second done and the first results stay put
    for (int i = 0; i < 40; i++) begin
      @(negedge clk);
      if (div_ready_o !== 1'b0) begin
        report_failure("second div_ready_o after an ignored start pulse");
      end
      held_q.dw = div_out_o;
      held_r.dw = rem_out_o;
      check_quot(name, exp.quot, held_q);
      check_rem(name, exp.rem, held_r);
    end
    // the next request leaves the old pair in place until its own done
    exp_next = ref_model(1'b1, 1'b0, 64'h8000_0000_0000_0007, 64'hffff_ffff_ffff_fffd);
    start_division(1'b1, 1'b0, 64'h8000_0000_0000_0007, 64'hffff_ffff_ffff_fffd);
    cycles = 0;
    while (div_ready_o !== 1'b1) begin
      if (cycles >= TIMEOUT) begin
        report_failure("timeout waiting for div_ready_o");
      end
      held_q.dw = div_out_o;
      held_r.dw = rem_out_o;
      check_quot(name, exp.quot, held_q);
      check_rem(name, exp.rem, held_r);
      @(negedge clk);
      cycles++;
    end
    held_q.dw = div_out_o;
    held_r.dw = rem_out_o;
    check_quot(name, exp_next.quot, held_q);
    check_rem(name, exp_next.rem, held_r);
  endtask

  task automatic run_random();
    logic [63:0]       flags;
    logic [63:0]       a;
    logic [63:0]       b;
    logic [63:0]       sel;
    logic [63:0]       sh;
    logic [NAME_W-1:0] name;
    div_res_t          exp;
    for (int i = 0; i < N_RANDOM; i++) begin
      draw_bits(2, flags);
      draw_bits(64, a);
      draw_bits(64, b);
      draw_bits(3, sel);
      draw_bits(6, sh);
      // bias toward corner cases and small divisors
      if (sel[2:0] == 3'd0) begin
        b = '0;
      end else if (sel[2:0] == 3'd1) begin
        if (flags[0]) begin
          a[31:0] = 32'h8000_0000;
          b[31:0] = '1;
        end else begin
          a = 64'h8000_0000_0000_0000;
          b = '1;
        end
      end else if (sel[2:0] <= 3'd4) begin
        b = b >> sh[5:0];
      end
      exp = ref_model(flags[1], flags[0], a, b);
      $sformat(name, "random_%0d", i);
      run_case(name, flags[1], flags[0], a, b, exp.quot, exp.rem);
    end
  endtask

  initial begin
    xlen_word_u zero_w;
    xlen_word_u out_w;
    clk            = 1'b0;
    rst_i          = 1'b1;
    signed_valid_i = 1'b0;
    div32_valid_i  = 1'b0;
    sr1_data_i     = '0;
    sr2_data_i     = '0;
    div_valid_i    = 1'b0;
    lfsr           = 32'hdcdb0b2a;
    zero_w.dw      = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    // outputs come out of reset cleared
    if (div_ready_o !== 1'b0) begin
      report_failure("div_ready_o is not low after reset");
    end
    out_w.dw = div_out_o;
    check_quot("reset", zero_w, out_w);
    out_w.dw = rem_out_o;
    check_rem("reset", zero_w, out_w);
    replay_patterns();
    check_extra_start();
    run_random();
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== alu_div_top.sv ====
`timescale 1ns/10ps

module alu_div_top
  import div_isa_pkg::*;
  import div_core_pkg::*;
#(
  // quotient bits per cycle: 1, 2 or 4
  parameter int unsigned STEP_BITS = 2
) (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            signed_valid_i,
  input  logic            div32_valid_i,
  input  logic [XLEN-1:0] sr1_data_i,
  input  logic [XLEN-1:0] sr2_data_i,
  input  logic            div_valid_i,
  output logic            div_ready_o,
  output logic [XLEN-1:0] div_out_o,
  output logic [XLEN-1:0] rem_out_o
);

  div_req_t  req;
  div_prep_t prep;
  div_res_t  raw;
  div_prep_t flags;
  div_res_t  res;

  // flat pipeline ports into one request
  assign req.op.is_signed = signed_valid_i;
  assign req.op.is_word   = div32_valid_i;
  // rs1 / rs2
  assign req.dividend.dw  = sr1_data_i;
  assign req.divisor.dw   = sr2_data_i;

  // magnitudes and special cases
  div_operand_prep u_prep (
    .req_i  (req),
    .prep_o (prep)
  );

  // unsigned iteration, variable latency
  div_iter_core #(
    .STEP_BITS (STEP_BITS)
  ) u_iter (
    .clk     (clk),
    .rst_i   (rst_i),
    .start_i (div_valid_i),
    .prep_i  (prep),
    .done_o  (div_ready_o),
    .raw_o   (raw),
    .flags_o (flags)
  );

  // signs, special results, word extension
  div_result_fix u_fix (
    .raw_i   (raw),
    .flags_i (flags),
    .res_o   (res)
  );

  assign div_out_o = res.quot.dw;
  assign rem_out_o = res.rem.dw;

endmodule

// ==== div_result_fix.sv ====
`timescale 1ns/10ps

module div_result_fix
  import div_isa_pkg::*;
  import div_core_pkg::*;
(
  input  div_res_t  raw_i,
  input  div_prep_t flags_i,
  output div_res_t  res_o
);

  // signed results before the word sign extension
  logic [XLEN-1:0] quot_s;
  logic [XLEN-1:0] rem_s;
  // original dividend rebuilt from its magnitude
  logic [XLEN-1:0] dvd_s;

  always_comb begin
    // two's complement where the held signs ask for it
    quot_s = flags_i.neg_q ? (~raw_i.quot.dw + 1'b1) : raw_i.quot.dw;
    rem_s  = flags_i.neg_r ? (~raw_i.rem.dw + 1'b1) : raw_i.rem.dw;
    dvd_s  = flags_i.neg_r ? (~flags_i.mag_a + 1'b1) : flags_i.mag_a;

    // x / 0: all ones and the dividend
    if (flags_i.by_zero) begin
      quot_s = '1;
      rem_s  = dvd_s;
    // min / -1: dividend back, nothing left over
    end else if (flags_i.ovf) begin
      quot_s = dvd_s;
      rem_s  = '0;
    end
  end

  always_comb begin
    res_o.quot.dw = quot_s;
    res_o.rem.dw  = rem_s;
    // *w results: bit 31 fills the upper half, even for divuw/remuw
    if (flags_i.op.is_word) begin
      res_o.quot.w.lo = quot_s[WORD_W-1:0];
      res_o.quot.w.hi = {WORD_W{quot_s[WORD_W-1]}};
      res_o.rem.w.lo  = rem_s[WORD_W-1:0];
      res_o.rem.w.hi  = {WORD_W{rem_s[WORD_W-1]}};
    end
  end

endmodule

// ==== div_iter_core.sv ====
`timescale 1ns/10ps

module div_iter_core
  import div_isa_pkg::*;
  import div_core_pkg::*;
#(
  parameter int unsigned STEP_BITS = 2
) (
  input  logic      clk,
  input  logic      rst_i,
  input  logic      start_i,
  input  div_prep_t prep_i,
  output logic      done_o,
  output div_res_t  raw_o,
  output div_prep_t flags_o
);

  // run lengths for both widths
  localparam int unsigned N_DW  = XLEN / STEP_BITS;
  localparam int unsigned N_W   = WORD_W / STEP_BITS;
  localparam int unsigned CNT_W = $clog2(N_DW);

  localparam logic [CNT_W-1:0] LAST_DW = CNT_W'(N_DW - 1);
  localparam logic [CNT_W-1:0] LAST_W  = CNT_W'(N_W - 1);

  div_state_e       state_q;
  // remaining RUN cycles minus one
  logic [CNT_W-1:0] cnt_q;
  // partial remainder, always below the divisor between steps
  logic [XLEN-1:0]  r_q;
  // dividend bits shift out the top, quotient bits shift in below
  logic [XLEN-1:0]  q_q;
  // operation held for the whole run
  div_prep_t        work_q;
  // published results, stable until the next run ends
  div_res_t         raw_q;
  div_prep_t        flags_q;

  logic             accept;
  logic             special;
  logic             last_run;
  logic [XLEN:0]    r_try;
  logic [XLEN-1:0]  r_nxt;
  logic [XLEN-1:0]  q_nxt;

  // start is only seen while idle, later pulses fall on the floor
  assign accept   = start_i && (state_q == IDLE);
  // results come from fixup, no iterations needed
  assign special  = work_q.by_zero | work_q.ovf;
  assign last_run = (state_q == RUN) && (cnt_q == '0);

  // STEP_BITS restoring steps unrolled into one cycle
  always_comb begin
    r_nxt = r_q;
    q_nxt = q_q;
    r_try = '0;
    for (int i = 0; i < STEP_BITS; i++) begin
      // bring down the next dividend bit
      r_try = {r_nxt, q_nxt[XLEN-1]};
      q_nxt = {q_nxt[XLEN-2:0], 1'b0};
      if (r_try >= {1'b0, work_q.mag_b}) begin
        r_try    = r_try - {1'b0, work_q.mag_b};
        q_nxt[0] = 1'b1;
      end
      r_nxt = r_try[XLEN-1:0];
    end
  end

  // control and published results
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      raw_q   <= '0;
      flags_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= RUN;
            // special cases spend a single cycle in RUN
            if (prep_i.by_zero || prep_i.ovf) begin
              cnt_q <= '0;
            end else if (prep_i.op.is_word) begin
              cnt_q <= LAST_W;
            end else begin
              cnt_q <= LAST_DW;
            end
          end
        end
        RUN: begin
          cnt_q <= cnt_q - 1'b1;
          if (last_run) begin
            state_q <= DONE;
            // fixup ignores the raw pair for special cases
            raw_q.quot.dw <= special ? '0 : q_nxt;
            raw_q.rem.dw  <= special ? '0 : r_nxt;
            flags_q       <= work_q;
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // working registers
  always_ff @(posedge clk) begin
    if (accept) begin
      work_q <= prep_i;
      r_q    <= '0;
      // word dividend is moved to the top so 32 steps finish it
      if (prep_i.op.is_word) begin
        q_q <= prep_i.mag_a << (XLEN - WORD_W);
      end else begin
        q_q <= prep_i.mag_a;
      end
    end else if ((state_q == RUN) && !special) begin
      r_q <= r_nxt;
      q_q <= q_nxt;
    end
  end

  assign done_o  = (state_q == DONE);
  assign raw_o   = raw_q;
  assign flags_o = flags_q;

endmodule

// ==== div_operand_prep.sv ====
`timescale 1ns/10ps

module div_operand_prep
  import div_isa_pkg::*;
  import div_core_pkg::*;
(
  input  div_req_t  req_i,
  output div_prep_t prep_o
);

  // operands widened to the datapath, sign or zero extended for words
  logic [XLEN-1:0] a_ext;
  logic [XLEN-1:0] b_ext;
  // operand signs, only meaningful for signed ops
  logic            sign_a;
  logic            sign_b;
  // special operand patterns at op width
  logic            b_zero;
  logic            a_min;
  logic            b_all_ones;

  always_comb begin
    if (req_i.op.is_word) begin
      // only the low halves count for word ops
      sign_a = req_i.op.is_signed & req_i.dividend.w.lo[WORD_W-1];
      sign_b = req_i.op.is_signed & req_i.divisor.w.lo[WORD_W-1];
      a_ext  = {{WORD_W{sign_a}}, req_i.dividend.w.lo};
      b_ext  = {{WORD_W{sign_b}}, req_i.divisor.w.lo};
      b_zero = (req_i.divisor.w.lo == '0);
      // 0x8000_0000
      a_min  = (req_i.dividend.w.lo == {1'b1, {(WORD_W-1){1'b0}}});
      b_all_ones = (req_i.divisor.w.lo == '1);
    end else begin
      sign_a = req_i.op.is_signed & req_i.dividend.dw[XLEN-1];
      sign_b = req_i.op.is_signed & req_i.divisor.dw[XLEN-1];
      a_ext  = req_i.dividend.dw;
      b_ext  = req_i.divisor.dw;
      b_zero = (req_i.divisor.dw == '0);
      a_min  = (req_i.dividend.dw == {1'b1, {(XLEN-1){1'b0}}});
      b_all_ones = (req_i.divisor.dw == '1);
    end
  end

  always_comb begin
    // magnitudes, most negative value maps onto itself as unsigned
    prep_o.mag_a = sign_a ? (~a_ext + 1'b1) : a_ext;
    prep_o.mag_b = sign_b ? (~b_ext + 1'b1) : b_ext;
    // quotient negative when the signs differ
    prep_o.neg_q = sign_a ^ sign_b;
    // remainder follows the dividend
    prep_o.neg_r = sign_a;
    prep_o.by_zero = b_zero;
    // overflow only exists for signed ops; by-zero cannot overlap with -1
    prep_o.ovf = req_i.op.is_signed & a_min & b_all_ones;
    prep_o.op = req_i.op;
  end

endmodule

// ==== div_core_pkg.sv ====
package div_core_pkg;

  import div_isa_pkg::*;

  // datapath width, two words; word mode only makes sense at 64
  localparam int unsigned XLEN = 2 * WORD_W;

  // operands after preparation, ready for the unsigned divider
  typedef struct packed {
    // |dividend|, or the raw value for unsigned ops
    logic [XLEN-1:0] mag_a;
    // |divisor|
    logic [XLEN-1:0] mag_b;
    // operand signs differ
    logic            neg_q;
    // dividend was negative
    logic            neg_r;
    // divisor is zero at op width
    logic            by_zero;
    // most negative / -1
    logic            ovf;
    div_op_t         op;
  } div_prep_t;

  // divider sequencing
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } div_state_e;

endpackage

// ==== div_isa_pkg.sv ====
package div_isa_pkg;

  // width of a word operation, half the datapath
  localparam int unsigned WORD_W = 32;

  // decoded divide flavour from the instruction
  typedef struct packed {
    // div/rem as opposed to divu/remu
    logic is_signed;
    // the *w forms, 32-bit operands and results
    logic is_word;
  } div_op_t;

  // two halves of a double word
  typedef struct packed {
    logic [WORD_W-1:0] hi;
    logic [WORD_W-1:0] lo;
  } xlen_half_t;

  // one register value, read as a whole or as two halves
  typedef union packed {
    logic [2*WORD_W-1:0] dw;
    // word ops only look at lo, hi carries the sign extension
    xlen_half_t w;
  } xlen_word_u;

  // request as issued by the pipeline
  typedef struct packed {
    div_op_t    op;
    // rs1
    xlen_word_u dividend;
    // rs2
    xlen_word_u divisor;
  } div_req_t;

  // result pair, used both raw and after sign fixup
  typedef struct packed {
    xlen_word_u quot;
    xlen_word_u rem;
  } div_res_t;

endpackage
